// File: source/av_out_pkg.sv
/*
 * Widths, expansion and extra output mode codes, OSD colours,
 * CSC coefficients and the pixel word types of the output path
 */
package av_out_pkg;

    localparam int COLOR_W = 8;
    localparam int PIXEL_W = 3 * COLOR_W;

    typedef logic [1:0] osd_color_t;

    localparam logic [PIXEL_W-1:0] OSD_BLACK  = 24'h000000;
    localparam logic [PIXEL_W-1:0] OSD_BLUE   = 24'h0000ff;
    localparam logic [PIXEL_W-1:0] OSD_YELLOW = 24'hffff00;
    localparam logic [PIXEL_W-1:0] OSD_WHITE  = 24'hffffff;

    // Expansion connector function
    typedef logic [1:0] exp_sel_t;

    localparam exp_sel_t EXP_SEL_OFF       = 2'd0;
    localparam exp_sel_t EXP_SEL_EXTRA_OUT = 2'd1;
    localparam exp_sel_t EXP_SEL_LEGACY_IN = 2'd2;
    localparam exp_sel_t EXP_SEL_UVC_BDG   = 2'd3;

    typedef logic [1:0] extra_out_mode_t;

    localparam extra_out_mode_t EXTRA_OUT_RGBHV = 2'd0;
    localparam extra_out_mode_t EXTRA_OUT_RGBCS = 2'd1;
    localparam extra_out_mode_t EXTRA_OUT_RGSB  = 2'd2;
    localparam extra_out_mode_t EXTRA_OUT_YPBPR = 2'd3;

    // CSC arithmetic, coefficients in 1/256 units
    localparam int CSC_COEF_W = 9;
    localparam int CSC_PROD_W = 18;
    localparam int CSC_SUM_W  = 20;
    localparam int CSC_SHIFT  = 8;

    localparam logic signed [CSC_COEF_W-1:0] CSC_Y_R  = 9'sd54;
    localparam logic signed [CSC_COEF_W-1:0] CSC_Y_G  = 9'sd183;
    localparam logic signed [CSC_COEF_W-1:0] CSC_Y_B  = 9'sd19;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PB_R = -9'sd29;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PB_G = -9'sd99;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PB_B = 9'sd128;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PR_R = 9'sd128;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PR_G = -9'sd116;
    localparam logic signed [CSC_COEF_W-1:0] CSC_PR_B = -9'sd12;
    localparam logic [COLOR_W-1:0] CSC_OFFSET = 8'd128;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic [COLOR_W-1:0] y;
        logic [COLOR_W-1:0] pb;
        logic [COLOR_W-1:0] pr;
    } ypbpr_t;

    // Same word, either colour space
    typedef union packed {
        rgb_t   rgb;
        ypbpr_t ypbpr;
    } pixel_word_t;

endpackage

// File: source/video_if.sv
/*
 * Pixel stream with syncs between output path blocks
 */
`timescale 1ns/10ps

interface video_if;

    av_out_pkg::pixel_word_t pixel;
    logic                    hsync;
    logic                    vsync;
    logic                    de;
    // Pixel word holds the YPbPr view
    logic                    ypbpr;

    modport src (
        output pixel,
        output hsync,
        output vsync,
        output de,
        output ypbpr
    );

    modport snk (
        input pixel,
        input hsync,
        input vsync,
        input de,
        input ypbpr
    );

endinterface

// File: source/osd_overlay.sv
/*
 * OSD colour overlay stage and HDMI transmitter output registers
 */
`timescale 1ns/10ps

module osd_overlay (
    input  logic                   pclk_out,
    input  logic                   po_reset_n,
    input  av_out_pkg::rgb_t       rgb_i,
    input  logic                   hsync_i,
    input  logic                   vsync_i,
    input  logic                   de_i,
    input  logic                   osd_enable_i,
    input  av_out_pkg::osd_color_t osd_color_i,
    video_if.src                   vid_o,
    output av_out_pkg::rgb_t       hdmitx_rgb_o,
    output logic                   hdmitx_hsync_o,
    output logic                   hdmitx_vsync_o,
    output logic                   hdmitx_de_o
);

    av_out_pkg::rgb_t osd_rgb;
    av_out_pkg::rgb_t ovl_rgb;
    logic             ovl_hsync;
    logic             ovl_vsync;
    logic             ovl_de;

    always_comb begin
        case (osd_color_i)
            2'd0:    osd_rgb = av_out_pkg::OSD_BLACK;
            2'd1:    osd_rgb = av_out_pkg::OSD_BLUE;
            2'd2:    osd_rgb = av_out_pkg::OSD_YELLOW;
            default: osd_rgb = av_out_pkg::OSD_WHITE;
        endcase
    end

    // Overlay stage
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ovl_rgb   <= '0;
            ovl_hsync <= 1'b0;
            ovl_vsync <= 1'b0;
            ovl_de    <= 1'b0;
        end else begin
            ovl_rgb   <= osd_enable_i ? osd_rgb : rgb_i;
            ovl_hsync <= hsync_i;
            ovl_vsync <= vsync_i;
            ovl_de    <= de_i;
        end
    end

    assign vid_o.pixel.rgb = ovl_rgb;
    assign vid_o.hsync     = ovl_hsync;
    assign vid_o.vsync     = ovl_vsync;
    assign vid_o.de        = ovl_de;
    assign vid_o.ypbpr     = 1'b0;

    // Second stage eases timing toward the transmitter pins
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmitx_rgb_o   <= '0;
            hdmitx_hsync_o <= 1'b0;
            hdmitx_vsync_o <= 1'b0;
            hdmitx_de_o    <= 1'b0;
        end else begin
            hdmitx_rgb_o   <= ovl_rgb;
            hdmitx_hsync_o <= ovl_hsync;
            hdmitx_vsync_o <= ovl_vsync;
            hdmitx_de_o    <= ovl_de;
        end
    end

endmodule

// File: source/output_csc.sv
/*
 * Two-stage RGB to YPbPr converter for the extra analog output
 * Syncs and pass-through pixels take the same two cycles
 */
`timescale 1ns/10ps

module output_csc (
    input  logic                        pclk_out,
    input  logic                        po_reset_n,
    input  av_out_pkg::extra_out_mode_t extra_out_mode_i,
    video_if.snk                        vid_i,
    video_if.src                        vid_o
);

    // Products, rows Y, Pb, Pr, columns R, G, B
    logic signed [av_out_pkg::CSC_PROD_W-1:0] prod_q [0:8];
    av_out_pkg::pixel_word_t                  s1_pixel;
    logic                                     s1_hsync;
    logic                                     s1_vsync;
    logic                                     s1_de;
    logic                                     s1_conv;

    logic signed [av_out_pkg::CSC_SUM_W-1:0]  sum_y;
    logic signed [av_out_pkg::CSC_SUM_W-1:0]  sum_pb;
    logic signed [av_out_pkg::CSC_SUM_W-1:0]  sum_pr;
    logic signed [av_out_pkg::CSC_SUM_W-1:0]  sh_y;
    logic signed [av_out_pkg::CSC_SUM_W-1:0]  sh_pb;
    logic signed [av_out_pkg::CSC_SUM_W-1:0]  sh_pr;
    av_out_pkg::pixel_word_t                  conv_pixel;

    av_out_pkg::pixel_word_t                  s2_pixel;
    logic                                     s2_hsync;
    logic                                     s2_vsync;
    logic                                     s2_de;
    logic                                     s2_ypbpr;

    function automatic logic signed [av_out_pkg::CSC_PROD_W-1:0] csc_mul(
        input logic signed [av_out_pkg::CSC_COEF_W-1:0] coef,
        input logic [av_out_pkg::COLOR_W-1:0]           ch
    );
        logic signed [av_out_pkg::CSC_PROD_W-1:0] coef_ext;
        logic signed [av_out_pkg::CSC_PROD_W-1:0] ch_ext;
        coef_ext = coef;
        ch_ext   = $signed({{(av_out_pkg::CSC_PROD_W-av_out_pkg::COLOR_W){1'b0}}, ch});
        return coef_ext * ch_ext;
    endfunction

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            for (int i = 0; i < 9; i++) begin
                prod_q[i] <= '0;
            end
            s1_pixel <= '0;
            s1_hsync <= 1'b0;
            s1_vsync <= 1'b0;
            s1_de    <= 1'b0;
            s1_conv  <= 1'b0;
        end else begin
            prod_q[0] <= csc_mul(av_out_pkg::CSC_Y_R, vid_i.pixel.rgb.r);
            prod_q[1] <= csc_mul(av_out_pkg::CSC_Y_G, vid_i.pixel.rgb.g);
            prod_q[2] <= csc_mul(av_out_pkg::CSC_Y_B, vid_i.pixel.rgb.b);
            prod_q[3] <= csc_mul(av_out_pkg::CSC_PB_R, vid_i.pixel.rgb.r);
            prod_q[4] <= csc_mul(av_out_pkg::CSC_PB_G, vid_i.pixel.rgb.g);
            prod_q[5] <= csc_mul(av_out_pkg::CSC_PB_B, vid_i.pixel.rgb.b);
            prod_q[6] <= csc_mul(av_out_pkg::CSC_PR_R, vid_i.pixel.rgb.r);
            prod_q[7] <= csc_mul(av_out_pkg::CSC_PR_G, vid_i.pixel.rgb.g);
            prod_q[8] <= csc_mul(av_out_pkg::CSC_PR_B, vid_i.pixel.rgb.b);
            s1_pixel  <= vid_i.pixel;
            s1_hsync  <= vid_i.hsync;
            s1_vsync  <= vid_i.vsync;
            s1_de     <= vid_i.de;
            s1_conv   <= (extra_out_mode_i == av_out_pkg::EXTRA_OUT_YPBPR);
        end
    end

    // Floor shift, then chroma offset; coefficients keep results in range
    always_comb begin
        sum_y  = prod_q[0] + prod_q[1] + prod_q[2];
        sum_pb = prod_q[3] + prod_q[4] + prod_q[5];
        sum_pr = prod_q[6] + prod_q[7] + prod_q[8];
        sh_y   = sum_y >>> av_out_pkg::CSC_SHIFT;
        sh_pb  = sum_pb >>> av_out_pkg::CSC_SHIFT;
        sh_pr  = sum_pr >>> av_out_pkg::CSC_SHIFT;
        conv_pixel.ypbpr.y  = sh_y[av_out_pkg::COLOR_W-1:0];
        conv_pixel.ypbpr.pb = sh_pb[av_out_pkg::COLOR_W-1:0] + av_out_pkg::CSC_OFFSET;
        conv_pixel.ypbpr.pr = sh_pr[av_out_pkg::COLOR_W-1:0] + av_out_pkg::CSC_OFFSET;
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            s2_pixel <= '0;
            s2_hsync <= 1'b0;
            s2_vsync <= 1'b0;
            s2_de    <= 1'b0;
            s2_ypbpr <= 1'b0;
        end else begin
            s2_pixel <= s1_conv ? conv_pixel : s1_pixel;
            s2_hsync <= s1_hsync;
            s2_vsync <= s1_vsync;
            s2_de    <= s1_de;
            s2_ypbpr <= s1_conv;
        end
    end

    assign vid_o.pixel = s2_pixel;
    assign vid_o.hsync = s2_hsync;
    assign vid_o.vsync = s2_vsync;
    assign vid_o.de    = s2_de;
    assign vid_o.ypbpr = s2_ypbpr;

endmodule

// File: source/vga_dac_encoder.sv
/*
 * VGA DAC encoder with sync and blank formatting per extra output mode
 */
`timescale 1ns/10ps

module vga_dac_encoder (
    input  logic                        pclk_out,
    input  logic                        po_reset_n,
    input  av_out_pkg::exp_sel_t        exp_sel_i,
    input  av_out_pkg::extra_out_mode_t extra_out_mode_i,
    video_if.snk                        vid_i,
    output av_out_pkg::rgb_t            dac_rgb_o,
    output logic                        vga_hs_o,
    output logic                        vga_vs_o,
    output logic                        vga_blank_n_o,
    output logic                        vga_sync_n_o,
    output logic                        vga_oe_o
);

    logic             enable;
    logic             rgbhv;
    logic             csync;
    av_out_pkg::rgb_t dac_in;

    av_out_pkg::rgb_t pre_rgb;
    logic             pre_hs;
    logic             pre_vs;
    logic             pre_blank_n;
    logic             pre_sync_n;

    assign enable = (exp_sel_i == av_out_pkg::EXP_SEL_EXTRA_OUT);
    assign rgbhv  = (extra_out_mode_i == av_out_pkg::EXTRA_OUT_RGBHV);
    assign csync  = ~(vid_i.hsync ^ vid_i.vsync);

    // DAC channel order for component video is Pr, Y, Pb
    always_comb begin
        if (vid_i.ypbpr) begin
            dac_in.r = vid_i.pixel.ypbpr.pr;
            dac_in.g = vid_i.pixel.ypbpr.y;
            dac_in.b = vid_i.pixel.ypbpr.pb;
        end else begin
            dac_in = vid_i.pixel.rgb;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            pre_rgb     <= '0;
            pre_hs      <= 1'b0;
            pre_vs      <= 1'b0;
            pre_blank_n <= 1'b0;
            pre_sync_n  <= 1'b0;
        end else if (enable) begin
            pre_rgb     <= dac_in;
            pre_hs      <= rgbhv ? vid_i.hsync : csync;
            pre_vs      <= rgbhv ? vid_i.vsync : 1'b1;
            pre_blank_n <= vid_i.ypbpr ? 1'b1 : vid_i.de;
            // Sync on green for RGsB and YPbPr
            pre_sync_n  <= ((extra_out_mode_i == av_out_pkg::EXTRA_OUT_RGSB) ||
                            (extra_out_mode_i == av_out_pkg::EXTRA_OUT_YPBPR)) ? csync : 1'b0;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            dac_rgb_o     <= '0;
            vga_hs_o      <= 1'b0;
            vga_vs_o      <= 1'b0;
            vga_blank_n_o <= 1'b0;
            vga_sync_n_o  <= 1'b0;
        end else if (enable) begin
            dac_rgb_o     <= pre_rgb;
            vga_hs_o      <= pre_hs;
            vga_vs_o      <= pre_vs;
            vga_blank_n_o <= pre_blank_n;
            vga_sync_n_o  <= pre_sync_n;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vga_oe_o <= 1'b0;
        end else begin
            vga_oe_o <= enable;
        end
    end

endmodule

// File: source/av_output_top.sv
/*
 * Output pixel path top level
 * OSD overlay to HDMI transmitter, CSC and DAC encoder to the VGA DAC
 */
`timescale 1ns/10ps

module av_output_top (
    input  logic                        pclk_out,
    input  logic                        po_reset_n,
    input  logic [av_out_pkg::COLOR_W-1:0] r_i,
    input  logic [av_out_pkg::COLOR_W-1:0] g_i,
    input  logic [av_out_pkg::COLOR_W-1:0] b_i,
    input  logic                        hsync_i,
    input  logic                        vsync_i,
    input  logic                        de_i,
    input  logic                        osd_enable_i,
    input  av_out_pkg::osd_color_t      osd_color_i,
    input  av_out_pkg::exp_sel_t        exp_sel_i,
    input  av_out_pkg::extra_out_mode_t extra_out_mode_i,
    output logic [av_out_pkg::COLOR_W-1:0] hdmitx_r_o,
    output logic [av_out_pkg::COLOR_W-1:0] hdmitx_g_o,
    output logic [av_out_pkg::COLOR_W-1:0] hdmitx_b_o,
    output logic                        hdmitx_hsync_o,
    output logic                        hdmitx_vsync_o,
    output logic                        hdmitx_de_o,
    output logic [av_out_pkg::COLOR_W-1:0] vga_r_o,
    output logic [av_out_pkg::COLOR_W-1:0] vga_g_o,
    output logic [av_out_pkg::COLOR_W-1:0] vga_b_o,
    output logic                        vga_hs_o,
    output logic                        vga_vs_o,
    output logic                        vga_blank_n_o,
    output logic                        vga_sync_n_o,
    output logic                        vga_oe_o
);

    av_out_pkg::rgb_t in_rgb;
    av_out_pkg::rgb_t hdmitx_rgb;
    av_out_pkg::rgb_t dac_rgb;

    video_if ovl_vid ();
    video_if dac_vid ();

    assign in_rgb = {r_i, g_i, b_i};

    osd_overlay u_osd_overlay (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .rgb_i          (in_rgb),
        .hsync_i        (hsync_i),
        .vsync_i        (vsync_i),
        .de_i           (de_i),
        .osd_enable_i   (osd_enable_i),
        .osd_color_i    (osd_color_i),
        .vid_o          (ovl_vid),
        .hdmitx_rgb_o   (hdmitx_rgb),
        .hdmitx_hsync_o (hdmitx_hsync_o),
        .hdmitx_vsync_o (hdmitx_vsync_o),
        .hdmitx_de_o    (hdmitx_de_o)
    );

    assign hdmitx_r_o = hdmitx_rgb.r;
    assign hdmitx_g_o = hdmitx_rgb.g;
    assign hdmitx_b_o = hdmitx_rgb.b;

    output_csc u_output_csc (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .extra_out_mode_i (extra_out_mode_i),
        .vid_i            (ovl_vid),
        .vid_o            (dac_vid)
    );

    vga_dac_encoder u_vga_dac_encoder (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .exp_sel_i        (exp_sel_i),
        .extra_out_mode_i (extra_out_mode_i),
        .vid_i            (dac_vid),
        .dac_rgb_o        (dac_rgb),
        .vga_hs_o         (vga_hs_o),
        .vga_vs_o         (vga_vs_o),
        .vga_blank_n_o    (vga_blank_n_o),
        .vga_sync_n_o     (vga_sync_n_o),
        .vga_oe_o         (vga_oe_o)
    );

    assign vga_r_o = dac_rgb.r;
    assign vga_g_o = dac_rgb.g;
    assign vga_b_o = dac_rgb.b;

endmodule

// File: verification/av_output_checker.sv
/*
 * Concurrent assertions on the output path top level
 */
`timescale 1ns/10ps

module av_output_checker (
    input logic                           pclk_out,
    input logic                           po_reset_n,
    input logic                           de_i,
    input av_out_pkg::extra_out_mode_t    extra_out_mode_i,
    input logic                           hdmitx_de_o,
    input logic [av_out_pkg::COLOR_W-1:0] vga_r_o,
    input logic [av_out_pkg::COLOR_W-1:0] vga_g_o,
    input logic [av_out_pkg::COLOR_W-1:0] vga_b_o,
    input logic                           vga_hs_o,
    input logic                           vga_vs_o,
    input logic                           vga_blank_n_o,
    input logic                           vga_sync_n_o,
    input logic                           vga_oe_o
);

    hdmi_de_latency: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        hdmitx_de_o == $past(de_i, 2))
        else $error("HDMI de differs from de_i two cycles earlier");

    // Composite sync modes tie VS high once the encoder is filled
    vga_vs_high: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        (vga_oe_o && $past(vga_oe_o) && $past(vga_oe_o, 2) &&
         extra_out_mode_i != av_out_pkg::EXTRA_OUT_RGBHV) |-> vga_vs_o)
        else $error("VGA VS low in a composite sync mode");

    vga_hold_when_off: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        !vga_oe_o |-> $stable({vga_r_o, vga_g_o, vga_b_o, vga_hs_o, vga_vs_o,
                               vga_blank_n_o, vga_sync_n_o}))
        else $error("VGA outputs changed while the extra output is off");

endmodule

bind av_output_top av_output_checker u_av_output_checker (.*);

// File: verification/av_output_tasks.svh
/*
 * Output prediction, drive, compare and directed test tasks
 */

function automatic av_out_pkg::rgb_t overlay_rgb(input av_out_pkg::rgb_t pix,
                                                 input logic osd_en,
                                                 input av_out_pkg::osd_color_t idx);
    av_out_pkg::rgb_t res;
    // Bit 1 lights red and green and bit 0 lights blue
    res.r = idx[1] ? 8'hff : 8'h00;
    res.g = idx[1] ? 8'hff : 8'h00;
    res.b = idx[0] ? 8'hff : 8'h00;
    return osd_en ? res : pix;
endfunction

// DAC carries Pr, Y, Pb on red, green, blue
function automatic av_out_pkg::rgb_t ypbpr_on_dac(input av_out_pkg::rgb_t pix);
    int r;
    int g;
    int b;
    int y;
    int pb;
    int pr;
    av_out_pkg::rgb_t dac;
    r  = int'(pix.r);
    g  = int'(pix.g);
    b  = int'(pix.b);
    y  = (54 * r + 183 * g + 19 * b) >>> 8;
    pb = ((-29 * r - 99 * g + 128 * b) >>> 8) + 128;
    pr = ((128 * r - 116 * g - 12 * b) >>> 8) + 128;
    dac.r = 8'(pr);
    dac.g = 8'(y);
    dac.b = 8'(pb);
    return dac;
endfunction

function automatic video_exp_t vga_expect(input av_out_pkg::rgb_t pix, input logic hs,
                                          input logic vs, input logic de,
                                          input av_out_pkg::extra_out_mode_t mode);
    video_exp_t want;
    logic       csync;
    logic       rgbhv;
    logic       ypbpr;
    csync       = ~(hs ^ vs);
    rgbhv       = (mode == av_out_pkg::EXTRA_OUT_RGBHV);
    ypbpr       = (mode == av_out_pkg::EXTRA_OUT_YPBPR);
    want.rgb    = ypbpr ? ypbpr_on_dac(pix) : pix;
    want.hs     = rgbhv ? hs : csync;
    want.vs     = rgbhv ? vs : 1'b1;
    want.de     = ypbpr ? 1'b1 : de;
    want.sync_n = (ypbpr || mode == av_out_pkg::EXTRA_OUT_RGSB) ? csync : 1'b0;
    return want;
endfunction

task automatic check_rgb(input av_out_pkg::rgb_t got, input av_out_pkg::rgb_t want,
                         input string what);
    if (got !== want) begin
        rgb_errors++;
        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
    end
endtask

task automatic check_sync(input logic got, input logic want, input string what);
    if (got !== want) begin
        sync_errors++;
        $display("FAIL %0t: %s is %b, expected %b", $time, what, got, want);
    end
endtask

task automatic wait_oe(input logic level);
    int cycles;
    cycles = 0;
    while (vga_oe_o !== level && cycles < 4) begin
        @(negedge pclk_out);
        cycles++;
    end
    if (vga_oe_o !== level) begin
        wait_errors++;
        $display("Timed out at %0t waiting for vga_oe_o to reach %0b", $time, level);
    end
endtask

// Compare what left the pipes, then drive the next pixel
task automatic push_pixel(input av_out_pkg::rgb_t pix, input logic hs, input logic vs,
                          input logic de, input logic osd_en,
                          input av_out_pkg::osd_color_t osd_idx);
    video_exp_t       want;
    av_out_pkg::rgb_t ovl;
    @(negedge pclk_out);
    if (hdmi_q.size() == 2) begin
        want = hdmi_q.pop_front();
        check_rgb({hdmitx_r_o, hdmitx_g_o, hdmitx_b_o}, want.rgb, "HDMI pixel");
        check_sync(hdmitx_hsync_o, want.hs, "HDMI hsync");
        check_sync(hdmitx_vsync_o, want.vs, "HDMI vsync");
        check_sync(hdmitx_de_o, want.de, "HDMI de");
    end
    if (vga_track && vga_q.size() == 5) begin
        want = vga_q.pop_front();
        check_rgb({vga_r_o, vga_g_o, vga_b_o}, want.rgb, "VGA pixel");
        check_sync(vga_hs_o, want.hs, "VGA HS");
        check_sync(vga_vs_o, want.vs, "VGA VS");
        check_sync(vga_blank_n_o, want.de, "VGA BLANK_N");
        check_sync(vga_sync_n_o, want.sync_n, "VGA SYNC_N");
    end
    {r_i, g_i, b_i} = pix;
    hsync_i      = hs;
    vsync_i      = vs;
    de_i         = de;
    osd_enable_i = osd_en;
    osd_color_i  = osd_idx;
    ovl          = overlay_rgb(pix, osd_en, osd_idx);
    want.rgb     = ovl;
    want.hs      = hs;
    want.vs      = vs;
    want.de      = de;
    want.sync_n  = 1'b0;
    hdmi_q.push_back(want);
    if (vga_track) begin
        vga_q.push_back(vga_expect(ovl, hs, vs, de, extra_out_mode_i));
    end
endtask

task automatic run_random(input int count, input logic osd_en,
                          input av_out_pkg::osd_color_t osd_idx);
    logic [31:0] word;
    repeat (count) begin
        word = $urandom;
        push_pixel(word[23:0], word[24], word[25], word[26], osd_en, osd_idx);
    end
endtask

// Mode only changes with the extra output deselected
task automatic select_output(input av_out_pkg::exp_sel_t sel,
                             input av_out_pkg::extra_out_mode_t mode);
    @(negedge pclk_out);
    exp_sel_i = av_out_pkg::EXP_SEL_OFF;
    @(negedge pclk_out);
    extra_out_mode_i = mode;
    exp_sel_i        = sel;
    repeat (6) @(negedge pclk_out);
    hdmi_q.delete();
    vga_q.delete();
    vga_track = (sel == av_out_pkg::EXP_SEL_EXTRA_OUT);
endtask

task automatic test_reset_values();
    check_rgb({hdmitx_r_o, hdmitx_g_o, hdmitx_b_o}, '0, "HDMI pixel after reset");
    check_sync(hdmitx_hsync_o, 1'b0, "HDMI hsync after reset");
    check_sync(hdmitx_vsync_o, 1'b0, "HDMI vsync after reset");
    check_sync(hdmitx_de_o, 1'b0, "HDMI de after reset");
    check_rgb({vga_r_o, vga_g_o, vga_b_o}, '0, "VGA pixel after reset");
    check_sync(vga_hs_o, 1'b0, "VGA HS after reset");
    check_sync(vga_vs_o, 1'b0, "VGA VS after reset");
    check_sync(vga_blank_n_o, 1'b0, "VGA BLANK_N after reset");
    check_sync(vga_sync_n_o, 1'b0, "VGA SYNC_N after reset");
    check_sync(vga_oe_o, 1'b0, "VGA output enable after reset");
endtask

task automatic test_hdmi_path();
    hdmi_q.delete();
    run_random(20, 1'b0, 2'd0);
    for (int idx = 0; idx < 4; idx++) begin
        run_random(6, 1'b1, 2'(idx));
    end
endtask

task automatic test_extra_out(input av_out_pkg::extra_out_mode_t mode);
    select_output(av_out_pkg::EXP_SEL_EXTRA_OUT, mode);
    wait_oe(1'b1);
    run_random(24, 1'b0, 2'd0);
endtask

task automatic test_output_off();
    av_out_pkg::rgb_t held_rgb;
    logic [3:0]       held_sync;
    run_random(4, 1'b0, 2'd0);
    // Encoder freezes at the next rising edge
    exp_sel_i = av_out_pkg::EXP_SEL_OFF;
    vga_track = 1'b0;
    vga_q.delete();
    held_rgb  = {vga_r_o, vga_g_o, vga_b_o};
    held_sync = {vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o};
    wait_oe(1'b0);
    hdmi_q.delete();
    repeat (12) begin
        run_random(1, 1'b0, 2'd0);
        check_rgb({vga_r_o, vga_g_o, vga_b_o}, held_rgb, "VGA pixel hold");
        check_sync(vga_hs_o, held_sync[3], "VGA HS hold");
        check_sync(vga_vs_o, held_sync[2], "VGA VS hold");
        check_sync(vga_blank_n_o, held_sync[1], "VGA BLANK_N hold");
        check_sync(vga_sync_n_o, held_sync[0], "VGA SYNC_N hold");
    end
endtask

// File: verification/av_output_tb.sv
/*
 * Testbench top for the output pixel path
 * Clock, reset, DUT instance and the directed test sequence
 */
`timescale 1ns/10ps

module av_output_tb;

    logic                              pclk_out;
    logic                              po_reset_n;
    logic [av_out_pkg::COLOR_W-1:0]    r_i;
    logic [av_out_pkg::COLOR_W-1:0]    g_i;
    logic [av_out_pkg::COLOR_W-1:0]    b_i;
    logic                              hsync_i;
    logic                              vsync_i;
    logic                              de_i;
    logic                              osd_enable_i;
    av_out_pkg::osd_color_t            osd_color_i;
    av_out_pkg::exp_sel_t              exp_sel_i;
    av_out_pkg::extra_out_mode_t       extra_out_mode_i;
    logic [av_out_pkg::COLOR_W-1:0]    hdmitx_r_o;
    logic [av_out_pkg::COLOR_W-1:0]    hdmitx_g_o;
    logic [av_out_pkg::COLOR_W-1:0]    hdmitx_b_o;
    logic                              hdmitx_hsync_o;
    logic                              hdmitx_vsync_o;
    logic                              hdmitx_de_o;
    logic [av_out_pkg::COLOR_W-1:0]    vga_r_o;
    logic [av_out_pkg::COLOR_W-1:0]    vga_g_o;
    logic [av_out_pkg::COLOR_W-1:0]    vga_b_o;
    logic                              vga_hs_o;
    logic                              vga_vs_o;
    logic                              vga_blank_n_o;
    logic                              vga_sync_n_o;
    logic                              vga_oe_o;

    // One predicted output sample, de doubles as BLANK_N on the VGA side
    typedef struct packed {
        av_out_pkg::rgb_t rgb;
        logic             hs;
        logic             vs;
        logic             de;
        logic             sync_n;
    } video_exp_t;

    // Oldest prediction first
    video_exp_t hdmi_q[$];
    video_exp_t vga_q[$];
    logic       vga_track;
    int         rgb_errors;
    int         sync_errors;
    int         wait_errors;

    av_output_top uut (.*);

    `include "av_output_tasks.svh"

    always #10 pclk_out = ~pclk_out;

    initial begin
        void'($urandom(90));
        pclk_out         = 1'b0;
        po_reset_n       = 1'b0;
        r_i              = '0;
        g_i              = '0;
        b_i              = '0;
        hsync_i          = 1'b0;
        vsync_i          = 1'b0;
        de_i             = 1'b0;
        osd_enable_i     = 1'b0;
        osd_color_i      = 2'd0;
        exp_sel_i        = av_out_pkg::EXP_SEL_OFF;
        extra_out_mode_i = av_out_pkg::EXTRA_OUT_RGBHV;
        vga_track        = 1'b0;
        rgb_errors       = 0;
        sync_errors      = 0;
        wait_errors      = 0;

        repeat (8) @(posedge pclk_out);
        @(negedge pclk_out);
        po_reset_n = 1'b1;

        test_reset_values();
        test_hdmi_path();
        test_extra_out(av_out_pkg::EXTRA_OUT_RGBHV);
        test_extra_out(av_out_pkg::EXTRA_OUT_RGBCS);
        test_extra_out(av_out_pkg::EXTRA_OUT_RGSB);
        test_extra_out(av_out_pkg::EXTRA_OUT_YPBPR);
        test_output_off();

        $display("Errors: pixel %0d, sync %0d, timeout %0d",
                 rgb_errors, sync_errors, wait_errors);
        if (rgb_errors + sync_errors + wait_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verification
source/av_out_pkg.sv
source/video_if.sv
source/osd_overlay.sv
source/output_csc.sv
source/vga_dac_encoder.sv
source/av_output_top.sv
verification/av_output_checker.sv
verification/av_output_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module av_output_tb -f filelist.f
	./obj_dir/Vav_output_tb | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
